/* project.f */
+incdir+hw
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/dmem_lane_if.sv
hw/mem_stage_memory1.sv
hw/dmem_byte_bank.sv
hw/mem_stage_memory2.sv
hw/mem_subsystem_top.sv
testbench/mem_checker.sv
testbench/tb_mem_subsystem.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = tb_mem_subsystem
FILELIST  = project.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = All tests passed

SIM     = $(OBJ_DIR)/V$(TOP)
SOURCES = $(wildcard hw/*.sv hw/*.svh testbench/*.sv)

.PHONY: all run check clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

check:
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* testbench/mem_trace.txt */
# stall flush valid pc addr store_data rd rd_we op(0 nop 1 load 2 store) size(0 b 1 h 2 w) signed br br_target
# expected: br br_target (this cycle) wb wb_data (wb pc, rd and rd_we are this line's own)
0 0 1 00001000 12345678 00000000 05 1 0 2 0 0 00000000 0 00000000 1 12345678
0 0 1 00001004 00000100 deadbeef 00 0 2 2 0 0 00000000 0 00000000 1 00000100
0 0 1 00001008 00000100 00000000 06 1 1 2 0 0 00000000 0 00000000 1 deadbeef
0 0 1 0000100c 00000101 000000a5 00 0 2 0 0 0 00000000 0 00000000 1 00000101
0 0 1 00001010 00000102 00008001 00 0 2 1 0 0 00000000 0 00000000 1 00000102
0 0 1 00001014 00000100 00000000 07 1 1 2 0 0 00000000 0 00000000 1 8001a5ef
0 0 1 00001018 00000101 00000000 08 1 1 0 1 0 00000000 0 00000000 1 ffffffa5
0 0 1 0000101c 00000101 00000000 09 1 1 0 0 0 00000000 0 00000000 1 000000a5
0 0 1 00001020 00000102 00000000 0a 1 1 1 1 0 00000000 0 00000000 1 ffff8001
0 0 1 00001024 00000102 00000000 0b 1 1 1 0 0 00000000 0 00000000 1 00008001
0 0 1 00001028 00000042 00000000 0c 1 0 2 0 1 00002000 0 00000000 1 00000042
0 0 0 0000102c 00000000 00000000 00 0 0 2 0 1 00003000 1 00002000 0 00000000
0 0 1 00001030 00000104 cafef00d 00 0 2 2 0 0 00000000 0 00000000 1 00000104
1 0 0 00000000 00000000 00000000 00 0 0 2 0 0 00000000 0 00000000 0 00000000
0 0 1 00001034 00000104 00000000 0d 1 1 2 0 0 00000000 0 00000000 1 cafef00d
1 0 0 00000000 00000000 00000000 00 0 0 2 0 0 00000000 0 00000000 0 00000000
1 0 0 00000000 00000000 00000000 00 0 0 2 0 0 00000000 0 00000000 0 00000000
0 0 1 00001038 00000777 00000000 0e 1 0 2 0 0 00000000 0 00000000 1 00000777
0 0 1 0000103c 00000108 11223344 00 0 2 2 0 0 00000000 0 00000000 0 00000000
0 1 1 00001040 00000999 00000000 0f 1 0 2 0 0 00000000 0 00000000 1 00000999
0 0 1 00001044 00000108 00000000 10 1 1 2 0 0 00000000 0 00000000 1 11223344
0 0 1 00001048 00000055 00000000 11 1 0 2 0 0 00000000 0 00000000 0 00000000
0 1 0 00000000 00000000 00000000 00 0 0 2 0 0 00000000 0 00000000 0 00000000

/* testbench/tb_mem_subsystem.sv */
// Trace is read from the project root; an item on a stalled trace line is never accepted
`timescale 1ns/1ps

module tb_mem_subsystem;

    localparam string TRACE_FILE   = "testbench/mem_trace.txt";
    localparam int    TRACE_FIELDS = 17;
    localparam int    MAX_LINES    = 1000;   // Guard on the read loop
    localparam int    DRAIN_LIMIT  = 50;     // Cycles allowed for the last writebacks

    logic                clk;
    logic                rst_n;
    logic                stall;
    logic                flush;
    logic                e_valid;
    isa_pkg::word_t      e_pc;
    isa_pkg::word_t      e_addr;
    isa_pkg::word_t      e_store_data;
    isa_pkg::reg_idx_t   e_rd_idx;
    logic                e_rd_we;
    isa_pkg::mem_op_e    e_mem_op;
    isa_pkg::mem_size_e  e_mem_size;
    logic                e_mem_signed;
    logic                e_branch_taken;
    isa_pkg::word_t      e_branch_target;
    logic                branch_taken;
    isa_pkg::word_t      branch_target;
    logic                wb_valid;
    isa_pkg::word_t      wb_pc;
    isa_pkg::reg_idx_t   wb_rd_idx;
    logic                wb_rd_we;
    isa_pkg::word_t      wb_data;

    logic                exp_br_taken;   // Expected values for the checker
    isa_pkg::word_t      exp_br_target;
    logic                exp_push;
    isa_pkg::word_t      exp_pc;
    isa_pkg::reg_idx_t   exp_rd_idx;
    logic                exp_rd_we;
    isa_pkg::word_t      exp_data;

    int                  check_count;
    int                  mismatch_count;
    int                  other_count;
    int                  pending;
    int                  tb_errors;
    logic [31:0]         fld [TRACE_FIELDS];   // Current trace line

    mem_subsystem_top mem_subsystem_top_inst (.*);

    mem_checker checker_inst (.*);

    initial clk = 1'b0;
    always #20 clk = ~clk;   // 40 ns period

    // Current fields onto the DUT inputs and the expected lines
    task automatic apply_fields();
        stall           = fld[0][0];
        flush           = fld[1][0];
        e_valid         = fld[2][0];
        e_pc            = fld[3];
        e_addr          = fld[4];
        e_store_data    = fld[5];
        e_rd_idx        = fld[6][4:0];
        e_rd_we         = fld[7][0];
        e_mem_op        = isa_pkg::mem_op_e'(fld[8][1:0]);
        e_mem_size      = isa_pkg::mem_size_e'(fld[9][1:0]);
        e_mem_signed    = fld[10][0];
        e_branch_taken  = fld[11][0];
        e_branch_target = fld[12];
        exp_br_taken    = fld[13][0];
        exp_br_target   = fld[14];
        exp_push        = fld[15][0];
        exp_pc          = fld[3];        // Writeback keeps the item's pc, rd and rd_we
        exp_rd_idx      = fld[6][4:0];
        exp_rd_we       = fld[7][0];
        exp_data        = fld[16];
    endtask

    task automatic drive_idle();
        foreach (fld[i]) begin
            fld[i] = '0;
        end
        apply_fields();
    endtask

    task automatic run_trace();
        int    fd;
        int    rc;
        int    lines;
        string line;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the trace file %s", TRACE_FILE);
            tb_errors++;
            return;
        end
        lines = 0;
        while (!$feof(fd) && lines < MAX_LINES) begin
            rc = $fgets(line, fd);
            lines++;
            if (rc > 0 && line.len() > 1 && line[0] != "#") begin   // Skip comments, blanks
                rc = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                             fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6],
                             fld[7], fld[8], fld[9], fld[10], fld[11], fld[12],
                             fld[13], fld[14], fld[15], fld[16]);
                if (rc != TRACE_FIELDS) begin
                    $display("Trace line %0d could not be parsed", lines);
                    tb_errors++;
                end else begin
                    @(negedge clk);
                    apply_fields();
                end
            end
        end
        $fclose(fd);
    endtask

    initial begin
        int cycles;
        tb_errors = 0;
        rst_n     = 1'b0;
        drive_idle();
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        run_trace();
        @(negedge clk);
        drive_idle();
        cycles = 0;
        while (pending != 0 && cycles < DRAIN_LIMIT) begin   // Drain in-flight items
            @(negedge clk);
            cycles++;
        end
        if (pending != 0) begin
            $display("Timeout waiting for writebacks, %0d expected items never appeared", pending);
            tb_errors++;
        end
        repeat (4) @(negedge clk);   // Catch stray late writebacks
        $display("Checks: %0d, mismatches: %0d, other errors: %0d",
                 check_count, mismatch_count, other_count + tb_errors);
        if (mismatch_count + other_count + tb_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* testbench/mem_checker.sv */
// Samples on rising edges; a stall-held writeback counts once, branch_target checked only when taken
`timescale 1ns/1ps

module mem_checker (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               stall,
    input  logic               branch_taken,
    input  isa_pkg::word_t     branch_target,
    input  logic               wb_valid,
    input  isa_pkg::word_t     wb_pc,
    input  isa_pkg::reg_idx_t  wb_rd_idx,
    input  logic               wb_rd_we,
    input  isa_pkg::word_t     wb_data,
    input  logic               exp_br_taken,    // For the cycle now ending
    input  isa_pkg::word_t     exp_br_target,
    input  logic               exp_push,        // Queue one expected writeback
    input  isa_pkg::word_t     exp_pc,
    input  isa_pkg::reg_idx_t  exp_rd_idx,
    input  logic               exp_rd_we,
    input  isa_pkg::word_t     exp_data,
    output int                 check_count,
    output int                 mismatch_count,
    output int                 other_count,
    output int                 pending          // Expected writebacks not yet seen
);

    typedef struct packed {
        isa_pkg::word_t    pc;
        isa_pkg::reg_idx_t rd_idx;
        logic              rd_we;
        isa_pkg::word_t    data;
    } wb_exp_s;

    wb_exp_s wb_q [$];   // In program order
    logic    wb_new;     // Writeback register loaded at the previous edge

    task automatic compare_word(input string name, input isa_pkg::word_t exp_val,
                                input isa_pkg::word_t act_val);
        check_count++;
        if (act_val !== exp_val) begin
            mismatch_count++;
            $display("Mismatch %s: expected 0x%08h, actual 0x%08h at %0t",
                     name, exp_val, act_val, $time);
        end
    endtask

    always @(posedge clk) begin
        wb_exp_s exp_item;
        wb_exp_s new_item;
        if (!rst_n) begin
            wb_new = 1'b0;
        end else begin
            compare_word("branch_taken", 32'(exp_br_taken), 32'(branch_taken));
            if (exp_br_taken) begin
                compare_word("branch_target", exp_br_target, branch_target);
            end
            if (wb_valid && wb_new) begin   // Fresh item only
                if (wb_q.size() == 0) begin
                    other_count++;
                    $display("Unexpected writeback for pc 0x%08h, nothing was expected", wb_pc);
                end else begin
                    exp_item = wb_q.pop_front();
                    compare_word("wb_pc", exp_item.pc, wb_pc);
                    compare_word("wb_rd_idx", 32'(exp_item.rd_idx), 32'(wb_rd_idx));
                    compare_word("wb_rd_we", 32'(exp_item.rd_we), 32'(wb_rd_we));
                    compare_word("wb_data", exp_item.data, wb_data);
                end
            end
            if (exp_push) begin
                new_item.pc     = exp_pc;
                new_item.rd_idx = exp_rd_idx;
                new_item.rd_we  = exp_rd_we;
                new_item.data   = exp_data;
                wb_q.push_back(new_item);
            end
            wb_new = !stall;   // Held register on a stalled edge
        end
        pending = wb_q.size();
    end

endmodule

/* hw/mem_subsystem_top.sv */
// Memory 1 through writeback; two items in flight at most, stall freezes both stages and banks
`timescale 1ns/1ps
`include "mem_cfg.svh"

module mem_subsystem_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                stall,
    input  logic                flush,

    input  logic                e_valid,
    input  isa_pkg::word_t      e_pc,
    input  isa_pkg::word_t      e_addr,            // ALU result or address
    input  isa_pkg::word_t      e_store_data,
    input  isa_pkg::reg_idx_t   e_rd_idx,
    input  logic                e_rd_we,
    input  isa_pkg::mem_op_e    e_mem_op,
    input  isa_pkg::mem_size_e  e_mem_size,
    input  logic                e_mem_signed,
    input  logic                e_branch_taken,
    input  isa_pkg::word_t      e_branch_target,

    output logic                branch_taken,
    output isa_pkg::word_t      branch_target,

    output logic                wb_valid,
    output isa_pkg::word_t      wb_pc,
    output isa_pkg::reg_idx_t   wb_rd_idx,
    output logic                wb_rd_we,
    output isa_pkg::word_t      wb_data
);

    pipe_pkg::e_to_m1_s   e_to_m1;
    pipe_pkg::m1_to_m2_s  m1_to_m2;
    logic                 m1_to_m2_valid;

    dmem_lane_if lanes [`MEM_LANES] ();   // One per byte lane

    // Plain ports into the execute payload
    always_comb begin
        e_to_m1.pc            = e_pc;
        e_to_m1.alu_result    = e_addr;
        e_to_m1.store_data    = e_store_data;
        e_to_m1.rd_idx        = e_rd_idx;
        e_to_m1.rd_we         = e_rd_we;
        e_to_m1.mem_op        = e_mem_op;
        e_to_m1.mem_size      = e_mem_size;
        e_to_m1.mem_signed    = e_mem_signed;
        e_to_m1.branch_taken  = e_branch_taken;
        e_to_m1.branch_target = e_branch_target;
    end

    mem_stage_memory1 memory1_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .stall          (stall),
        .flush          (flush),
        .e_valid        (e_valid),
        .e_to_m1        (e_to_m1),
        .branch_taken   (branch_taken),
        .branch_target  (branch_target),
        .m1_to_m2_valid (m1_to_m2_valid),
        .m1_to_m2       (m1_to_m2),
        .lanes          (lanes)
    );

    for (genvar i = 0; i < `MEM_LANES; i++) begin : g_bank
        dmem_byte_bank bank_inst (
            .clk  (clk),
            .lane (lanes[i])
        );
    end

    mem_stage_memory2 memory2_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .stall          (stall),
        .m1_to_m2_valid (m1_to_m2_valid),
        .m1_to_m2       (m1_to_m2),
        .lanes          (lanes),
        .wb_valid       (wb_valid),
        .wb_pc          (wb_pc),
        .wb_rd_idx      (wb_rd_idx),
        .wb_rd_we       (wb_rd_we),
        .wb_data        (wb_data)
    );

endmodule

/* hw/mem_stage_memory2.sv */
// Aligned loads only; a held writeback register keeps wb_valid high through a stall
`timescale 1ns/1ps
`include "mem_cfg.svh"

module mem_stage_memory2 (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 stall,

    input  logic                 m1_to_m2_valid,
    input  pipe_pkg::m1_to_m2_s  m1_to_m2,

    dmem_lane_if.memory2         lanes [`MEM_LANES],

    output logic                 wb_valid,
    output isa_pkg::word_t       wb_pc,
    output isa_pkg::reg_idx_t    wb_rd_idx,
    output logic                 wb_rd_we,
    output isa_pkg::word_t       wb_data
);

    isa_pkg::word_t            lane_word;
    isa_pkg::word_t            shifted;
    isa_pkg::word_t            load_val;
    isa_pkg::word_t            rd_val;
    logic [`MEM_OFS_BITS-1:0]  ld_ofs;

    // Lane bytes back into a word, lane 0 lowest
    for (genvar i = 0; i < `MEM_LANES; i++) begin : g_merge
        assign lane_word[8*i +: 8] = lanes[i].rd_byte;
    end

    assign ld_ofs  = m1_to_m2.alu_result[`MEM_OFS_BITS-1:0];
    assign shifted = lane_word >> {ld_ofs, 3'b000};   // Addressed byte to bit 0

    always_comb begin
        unique case (m1_to_m2.mem_size)
            isa_pkg::MEM_SIZE_BYTE: begin
                // Sign bit is bit 7 of the picked byte
                load_val = {{24{m1_to_m2.mem_signed & shifted[7]}}, shifted[7:0]};
            end
            isa_pkg::MEM_SIZE_HALF: begin
                load_val = {{16{m1_to_m2.mem_signed & shifted[15]}}, shifted[15:0]};
            end
            default: begin
                load_val = shifted;   // Word, no extension
            end
        endcase
    end

    // Only loads take memory data
    assign rd_val = (m1_to_m2.mem_op == isa_pkg::MEM_OP_LOAD) ? load_val : m1_to_m2.alu_result;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
        end else if (!stall) begin
            wb_valid <= m1_to_m2_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            wb_pc     <= m1_to_m2.pc;
            wb_rd_idx <= m1_to_m2.rd_idx;
            wb_rd_we  <= m1_to_m2.rd_we;
            wb_data   <= rd_val;
        end
    end

    // Valid path from memory 1 must settle once out of reset
    a_wb_valid_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(wb_valid));

endmodule

/* hw/dmem_byte_bank.sv */
// Byte RAM with no reset on contents; a write returns the old byte on the same edge
`timescale 1ns/1ps
`include "mem_cfg.svh"

module dmem_byte_bank (
    input  logic      clk,
    dmem_lane_if.bank lane
);

    isa_pkg::byte_t mem [`MEM_DEPTH_WORDS];
    isa_pkg::byte_t rd_q;   // Read register, held on stall

    always_ff @(posedge clk) begin
        if (!lane.req_stall) begin
            if (lane.req_we) begin
                mem[lane.req_idx] <= lane.req_wdata;
            end
            rd_q <= mem[lane.req_idx];   // Read before write
        end
    end

    assign lane.rd_byte = rd_q;

    // A store strobe from memory 1 must come with a known index
    a_idx_known: assert property (@(posedge clk)
        lane.req_we |-> !$isunknown(lane.req_idx));

endmodule

/* hw/mem_stage_memory1.sv */
// Memory 1 is always ready; accesses must be aligned, and a flushed store has already written
`timescale 1ns/1ps
`include "mem_cfg.svh"

module mem_stage_memory1 (
    input  logic                 clk,
    input  logic                 rst_n,

    input  logic                 stall,
    input  logic                 flush,

    input  logic                 e_valid,
    input  pipe_pkg::e_to_m1_s   e_to_m1,

    output logic                 branch_taken,
    output isa_pkg::word_t       branch_target,

    output logic                 m1_to_m2_valid,
    output pipe_pkg::m1_to_m2_s  m1_to_m2,

    dmem_lane_if.memory1         lanes [`MEM_LANES]
);

    logic                      ff_in_valid;
    pipe_pkg::e_to_m1_s        ff_in;
    logic [`MEM_OFS_BITS-1:0]  req_ofs;
    logic [`MEM_LANES-1:0]     byte_en;
    isa_pkg::word_t            store_lanes;
    logic                      req_store;

    // Valid flop, the only control state here
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ff_in_valid <= 1'b0;
        end else if (!stall) begin
            ff_in_valid <= e_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            ff_in <= e_to_m1;   // Payload
        end
    end

    // Banks capture at the same edge as ff_in, so requests come from the inputs
    assign req_ofs   = e_to_m1.alu_result[`MEM_OFS_BITS-1:0];
    assign req_store = e_valid && (e_to_m1.mem_op == isa_pkg::MEM_OP_STORE);

    always_comb begin
        unique case (e_to_m1.mem_size)
            isa_pkg::MEM_SIZE_BYTE: begin
                byte_en     = `MEM_LANES'(1) << req_ofs;
                store_lanes = {4{e_to_m1.store_data[7:0]}};    // Byte on every lane
            end
            isa_pkg::MEM_SIZE_HALF: begin
                byte_en     = `MEM_LANES'(3) << req_ofs;
                store_lanes = {2{e_to_m1.store_data[15:0]}};   // Half on both halves
            end
            default: begin
                byte_en     = '1;                               // Whole word
                store_lanes = e_to_m1.store_data;
            end
        endcase
    end

    for (genvar i = 0; i < `MEM_LANES; i++) begin : g_lane
        assign lanes[i].req_idx   = e_to_m1.alu_result[`MEM_OFS_BITS +: `MEM_IDX_BITS];
        assign lanes[i].req_we    = req_store && byte_en[i];
        assign lanes[i].req_wdata = store_lanes[8*i +: 8];
        assign lanes[i].req_stall = stall;
    end

    // Branch report, not gated by flush
    assign branch_taken  = ff_in_valid && ff_in.branch_taken;
    assign branch_target = ff_in.branch_target;

    assign m1_to_m2_valid = ff_in_valid && !flush && !stall;

    always_comb begin
        m1_to_m2.pc         = ff_in.pc;
        m1_to_m2.alu_result = ff_in.alu_result;
        m1_to_m2.rd_idx     = ff_in.rd_idx;
        m1_to_m2.rd_we      = ff_in.rd_we;
        m1_to_m2.mem_op     = ff_in.mem_op;
        m1_to_m2.mem_size   = ff_in.mem_size;
        m1_to_m2.mem_signed = ff_in.mem_signed;
    end

    // Lane merge in memory 2 relies on accepted accesses being aligned
    a_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        (e_valid && !stall && e_to_m1.mem_op != isa_pkg::MEM_OP_NOP) |->
            ((e_to_m1.mem_size == isa_pkg::MEM_SIZE_WORD) ? (req_ofs == '0) :
             (e_to_m1.mem_size == isa_pkg::MEM_SIZE_HALF) ? !req_ofs[0] : 1'b1));

endmodule

/* hw/dmem_lane_if.sv */
// One byte lane of the data memory; no handshake, the bank samples on every edge without stall
`timescale 1ns/1ps
`include "mem_cfg.svh"

interface dmem_lane_if;

    logic [`MEM_IDX_BITS-1:0] req_idx;     // Word index in the bank
    logic                     req_we;      // Store strobe for this lane
    isa_pkg::byte_t           req_wdata;   // Byte to store
    logic                     req_stall;   // Hold bank registers
    isa_pkg::byte_t           rd_byte;     // Registered read byte

    // Request side, driven from memory 1 inputs
    modport memory1 (output req_idx, req_we, req_wdata, req_stall);

    // The RAM itself
    modport bank (input req_idx, req_we, req_wdata, req_stall, output rd_byte);

    // Read side, drained by memory 2
    modport memory2 (input rd_byte);

endinterface

/* hw/pipe_pkg.sv */
// Stage payloads as packed structs; no CSR or forwarding fields are carried
package pipe_pkg;

    // Execute to memory 1
    typedef struct packed {
        isa_pkg::word_t     pc;
        isa_pkg::word_t     alu_result;     // Address for loads and stores
        isa_pkg::word_t     store_data;
        isa_pkg::reg_idx_t  rd_idx;
        logic               rd_we;
        isa_pkg::mem_op_e   mem_op;
        isa_pkg::mem_size_e mem_size;
        logic               mem_signed;     // Loads only
        logic               branch_taken;
        isa_pkg::word_t     branch_target;
    } e_to_m1_s;

    // Memory 1 to memory 2, branch and store fields already consumed
    typedef struct packed {
        isa_pkg::word_t     pc;
        isa_pkg::word_t     alu_result;
        isa_pkg::reg_idx_t  rd_idx;
        logic               rd_we;
        isa_pkg::mem_op_e   mem_op;
        isa_pkg::mem_size_e mem_size;
        logic               mem_signed;
    } m1_to_m2_s;

endpackage

/* hw/isa_pkg.sv */
// RV32 base only; no atomics, so the op set stays NOP, LOAD and STORE
package isa_pkg;

    // Data and address word
    typedef logic [31:0] word_t;

    // One byte lane
    typedef logic [7:0] byte_t;

    // Destination register index, x0..x31
    typedef logic [4:0] reg_idx_t;

    // Memory operation of an instruction
    typedef enum logic [1:0] {
        MEM_OP_NOP,   // ALU result only
        MEM_OP_LOAD,
        MEM_OP_STORE
    } mem_op_e;

    // Access size, from funct3[1:0]
    typedef enum logic [1:0] {
        MEM_SIZE_BYTE,
        MEM_SIZE_HALF,
        MEM_SIZE_WORD
    } mem_size_e;

endpackage

/* hw/mem_cfg.svh */
// Bank geometry for a 32-bit word; lane count must stay a power of two and depth must stay >= 2
`ifndef MEM_CFG_SVH
`define MEM_CFG_SVH

// Byte lanes per data word
`define MEM_LANES 4

// Words held by each byte bank
`define MEM_DEPTH_WORDS 256

// Word index width inside one bank
`define MEM_IDX_BITS $clog2(`MEM_DEPTH_WORDS)

// Byte offset bits below the word index
`define MEM_OFS_BITS $clog2(`MEM_LANES)

`endif
